// File: bench/replay_timing_tb.sv
`timescale 1ns/1ps

module replay_timing_tb import replay_pkg::*; ();

  localparam int unit_width = 16;
  localparam int time_width = 48;
  localparam int data_width = 32;
  localparam int n_records  = 24;
  localparam int max_gap    = 3;
  localparam int rec_unit   = 5;
  // per record budget scaled by unit length and the widest timestamp step
  localparam int timeout_cycles = 20 * n_records * rec_unit * max_gap + 2000;

  logic clk;
  logic reset;
  logic [reg_addr_width-1:0] s_axi_awaddr;
  logic s_axi_awvalid, s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0] s_axi_wstrb;
  logic s_axi_wvalid, s_axi_wready;
  logic [1:0] s_axi_bresp;
  logic s_axi_bvalid, s_axi_bready;
  logic [reg_addr_width-1:0] s_axi_araddr;
  logic s_axi_arvalid, s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0] s_axi_rresp;
  logic s_axi_rvalid, s_axi_rready;
  logic in_valid, in_ready, out_valid, out_ready;
  logic [time_width-1:0] in_time, out_time, time_elapsed;
  logic [data_width-1:0] in_data, out_data;
  logic unit_pulse, send_hb_up_pulse, stall_dn;
  integer seed;
  int cycle_count;

  replay_timing_top #(
    .unit_width (unit_width),
    .time_width (time_width),
    .data_width (data_width)
  ) DUT (.*);

  // wall clock after n unit pulses since a restart
  function automatic logic [time_width-1:0] expected_time(input int unsigned n);
    return time_width'(1) + time_width'(n);
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_time(input string name, input logic [time_width-1:0] got,
                            input logic [time_width-1:0] want);
    if (got !== want) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want));
    end
  endtask

  task automatic check_data(input string name, input logic [data_width-1:0] got,
                            input logic [data_width-1:0] want);
    if (got !== want) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] want);
    if (got !== want) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want));
    end
  endtask

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // cycle limit for the whole run
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    abort_run("timeout, the run did not finish within the cycle limit");
  end

  task automatic axi_write(input logic [reg_addr_width-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    logic aw_go;
    logic w_go;
    @(negedge clk);
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b1;
    // each channel drops its valid after its own accept
    while (s_axi_awvalid || s_axi_wvalid) begin
      aw_go = s_axi_awvalid && s_axi_awready;
      w_go  = s_axi_wvalid && s_axi_wready;
      @(negedge clk);
      if (aw_go) s_axi_awvalid = 1'b0;
      if (w_go) s_axi_wvalid = 1'b0;
    end
    while (!s_axi_bvalid) @(negedge clk);
    resp = s_axi_bresp;
    @(negedge clk);
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [reg_addr_width-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp, output logic [time_width-1:0] time_at_ar);
    @(negedge clk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b1;
    while (!s_axi_arready) @(negedge clk);
    // wall clock as seen on the address handshake cycle
    time_at_ar = time_elapsed;
    @(negedge clk);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge clk);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    @(negedge clk);
    s_axi_rready = 1'b0;
  endtask

  // restart the wall clock and follow pulse spacing and heartbeat cycle by cycle
  task automatic check_clock_rate(input int unit_len, input int hb_every, input int n_pulses);
    int pulses;
    int gap;
    logic hb_next;
    logic [1:0] resp;
    pulses  = 0;
    gap     = 0;
    hb_next = 1'b0;
    axi_write(ctrl_addr, 32'h1, 4'hF, resp);
    check_resp("bresp ctrl", resp, axi_resp_okay);
    check_flag("unit_pulse", unit_pulse, 1'b0);
    repeat (n_pulses * unit_len + 2) begin
      check_time("time_elapsed", time_elapsed, expected_time(pulses));
      // heartbeat trails every hb_every-th pulse by one cycle
      check_flag("send_hb_up_pulse", send_hb_up_pulse, hb_next);
      hb_next = 1'b0;
      if (unit_pulse) begin
        check_word("unit pulse spacing", 32'(gap), 32'(unit_len));
        pulses++;
        hb_next = (pulses % hb_every == 0);
        gap = 0;
      end
      @(negedge clk);
      gap++;
    end
    check_word("unit pulse count", 32'(pulses), 32'(n_pulses));
  endtask

  task automatic check_readback(input logic [31:0] lo, input logic [31:0] hi,
                                input logic [time_width-1:0] t_ar);
    logic [time_width-1:0] want;
    want = t_ar;
    // the clock may step once before the slave latches it
    if ({hi, lo} == 64'(t_ar + time_width'(1))) want = t_ar + time_width'(1);
    check_word("time_lo", lo, want[31:0]);
    check_word("time_hi", hi, 32'(want[time_width-1:32]));
  endtask

  // records in and out in one process so queue order is fixed
  task automatic run_records();
    logic [time_width-1:0] ts;
    logic [time_width-1:0] q_time[$];
    logic [data_width-1:0] q_data[$];
    logic [time_width-1:0] prev_time;
    logic [data_width-1:0] prev_data;
    logic hold_prev;
    logic in_fire;
    logic stall_known;
    logic stall_want;
    int n_sent;
    int n_recv;
    int due_wait;
    // start a little in the past so the first records are already due
    ts          = time_elapsed - time_width'(2);
    hold_prev   = 1'b0;
    stall_known = 1'b0;
    stall_want  = 1'b0;
    n_sent      = 0;
    n_recv      = 0;
    due_wait    = 0;
    @(negedge clk);
    in_valid  = 1'b1;
    in_time   = ts;
    in_data   = $random(seed);
    out_ready = ($random(seed) & 3) != 0;
    while (n_recv < n_records) begin
      // in_ready follows out_ready so sample after it settles
      #1;
      if (hold_prev) begin
        check_flag("out_valid", out_valid, 1'b1);
        check_time("out_time", out_time, prev_time);
        check_data("out_data", out_data, prev_data);
      end
      if (q_time.size() > 0 && q_time[0] < time_elapsed && !out_valid) due_wait++;
      else due_wait = 0;
      if (due_wait > 4) abort_run("a record behind the wall clock was held too long");
      if (stall_known) check_flag("stall_dn", stall_dn, stall_want);
      // queue front is the record the gate holds this cycle
      // stall flag shows it against this cycle's wall clock one cycle later
      stall_known = q_time.size() > 0;
      if (stall_known) stall_want = q_time[0] > time_elapsed;
      if (out_valid && out_ready) begin
        if (q_time.size() == 0) begin
          abort_run("a record came out that was never sent");
        end else begin
          check_time("out_time", out_time, q_time.pop_front());
          check_data("out_data", out_data, q_data.pop_front());
          if (time_elapsed < out_time) abort_run("a record left before its timestamp");
          n_recv++;
        end
      end
      hold_prev = out_valid && !out_ready;
      prev_time = out_time;
      prev_data = out_data;
      in_fire   = in_valid && in_ready;
      if (in_fire) begin
        q_time.push_back(in_time);
        q_data.push_back(in_data);
        n_sent++;
      end
      @(negedge clk);
      if (in_fire && n_sent < n_records) begin
        // non-decreasing timestamps with small gaps
        ts      = ts + time_width'($unsigned($random(seed)) % (max_gap + 1));
        in_time = ts;
        in_data = $random(seed);
      end else if (in_fire) begin
        in_valid = 1'b0;
      end
      out_ready = ($random(seed) & 3) != 0;
    end
    // nothing extra may follow the last record
    repeat (4) begin
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);
    end
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] hi;
    logic [1:0] resp;
    logic [time_width-1:0] t_ar;
    logic [time_width-1:0] t_hi;
    seed          = 32'h64f2_9b94;
    reset         = 1'b1;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    in_valid      = 1'b0;
    in_time       = '0;
    in_data       = '0;
    out_ready     = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // idle state straight out of reset
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("s_axi_awready", s_axi_awready, 1'b1);
    check_flag("s_axi_wready", s_axi_wready, 1'b1);
    check_flag("s_axi_arready", s_axi_arready, 1'b1);
    check_flag("s_axi_bvalid", s_axi_bvalid, 1'b0);
    check_flag("s_axi_rvalid", s_axi_rvalid, 1'b0);
    check_flag("unit_pulse", unit_pulse, 1'b0);
    check_flag("send_hb_up_pulse", send_hb_up_pulse, 1'b0);
    check_flag("stall_dn", stall_dn, 1'b0);
    check_time("time_elapsed", time_elapsed, expected_time(0));
    // register defaults then byte-enabled writes and error responses
    axi_read(unit_len_addr, word, resp, t_ar);
    check_resp("rresp unit_len", resp, axi_resp_okay);
    check_word("unit_len", word, 32'd4);
    axi_read(hb_every_addr, word, resp, t_ar);
    check_word("hb_every", word, 32'd8);
    axi_write(unit_len_addr, 32'd5, 4'hF, resp);
    check_resp("bresp unit_len", resp, axi_resp_okay);
    // only the low byte lands
    axi_write(hb_every_addr, 32'h0000_1203, 4'b0001, resp);
    axi_read(unit_len_addr, word, resp, t_ar);
    check_word("unit_len", word, 32'd5);
    axi_read(hb_every_addr, word, resp, t_ar);
    check_word("hb_every", word, 32'd3);
    axi_write(time_lo_addr, 32'h1, 4'hF, resp);
    check_resp("bresp time_lo", resp, axi_resp_slverr);
    axi_read(8'h20, word, resp, t_ar);
    check_resp("rresp unmapped", resp, axi_resp_slverr);
    axi_read(ctrl_addr, word, resp, t_ar);
    check_word("ctrl", word, 32'd0);
    check_clock_rate(5, 3, 9);
    axi_write(unit_len_addr, 32'd2, 4'hF, resp);
    axi_write(hb_every_addr, 32'd1, 4'hF, resp);
    check_clock_rate(2, 1, 6);
    axi_write(unit_len_addr, 32'(rec_unit), 4'hF, resp);
    repeat (3) begin
      axi_read(time_lo_addr, word, resp, t_ar);
      check_resp("rresp time_lo", resp, axi_resp_okay);
      axi_read(time_hi_addr, hi, resp, t_hi);
      check_resp("rresp time_hi", resp, axi_resp_okay);
      check_readback(word, hi, t_ar);
    end
    run_records();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: design/replay_gate.sv
`timescale 1ns/1ps

module replay_gate import replay_pkg::*; #(
  parameter int time_width = 48,
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [time_width-1:0] in_time,
  input  logic [data_width-1:0] in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [time_width-1:0] out_time,
  output logic [data_width-1:0] out_data,
  input  logic                  stall_dn,
  output logic [time_width-1:0] pc_time_elapsed
);

  gate_state_e           state;
  logic [time_width-1:0] held_time;
  logic [data_width-1:0] held_data;
  // record already shown downstream, must stay until taken
  logic                  offered;
  logic                  out_fire;
  logic                  in_fire;

  // once offered, a late stall cannot withdraw the record
  assign out_valid = (state == gate_armed) && (!stall_dn || offered);
  assign out_fire  = out_valid && out_ready;
  // refill on the same cycle the held record leaves
  assign in_ready  = (state == gate_empty) || out_fire;
  assign in_fire   = in_valid && in_ready;

  assign out_time  = held_time;
  assign out_data  = held_data;
  // empty gate never stalls the time manager's flag
  assign pc_time_elapsed = (state == gate_empty) ? '0 : held_time;

  // record payload
  always_ff @(posedge clk) begin
    if (in_fire) begin
      held_time <= in_time;
      held_data <= in_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= gate_empty;
      offered <= 1'b0;
    end else begin
      offered <= out_valid && !out_ready;
      case (state)
        gate_empty: begin
          if (in_fire) state <= gate_settle;
        end
        // one cycle for stall_dn to see the new timestamp
        gate_settle: state <= gate_armed;
        gate_armed: begin
          if (out_fire) state <= in_fire ? gate_settle : gate_empty;
        end
        default: state <= gate_empty;
      endcase
    end
  end

  // back-pressure keeps the offer and its payload steady
  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=>
      (out_valid && $stable(out_time) && $stable(out_data)));

endmodule

// File: design/replay_pkg.sv
package replay_pkg;

  // host register window is small, one byte address per word
  localparam int reg_addr_width = 8;

  // register map, byte addresses of 32-bit words
  typedef enum logic [reg_addr_width-1:0] {
    // bit 0 written as one restarts the wall clock, reads as zero
    ctrl_addr     = 8'h00,
    // clk cycles per time unit
    unit_len_addr = 8'h04,
    // time units between upstream heartbeats
    hb_every_addr = 8'h08,
    // wall clock bits 31..0, read only
    time_lo_addr  = 8'h0C,
    // wall clock upper bits, zero-extended, read only
    time_hi_addr  = 8'h10
  } reg_addr_e;

  // axi4-lite response codes
  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

  // replay gate sequencing
  typedef enum logic [1:0] {
    // nothing held, ready for a record
    gate_empty  = 2'd0,
    // record just loaded, stall flag still reflects the previous one
    gate_settle = 2'd1,
    // record held, waiting for the wall clock to catch up
    gate_armed  = 2'd2
  } gate_state_e;

endpackage

// File: design/replay_timing_top.sv
`timescale 1ns/1ps

module replay_timing_top import replay_pkg::*; #(
  parameter int unit_width = 16,
  parameter int time_width = 48,
  parameter int data_width = 32
) (
  input  logic                      clk,
  input  logic                      reset,
  // host register access
  input  logic [reg_addr_width-1:0] s_axi_awaddr,
  input  logic                      s_axi_awvalid,
  output logic                      s_axi_awready,
  input  logic [31:0]               s_axi_wdata,
  input  logic [3:0]                s_axi_wstrb,
  input  logic                      s_axi_wvalid,
  output logic                      s_axi_wready,
  output logic [1:0]                s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  logic                      s_axi_bready,
  input  logic [reg_addr_width-1:0] s_axi_araddr,
  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,
  output logic [31:0]               s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  logic                      s_axi_rready,
  // timestamped records from the parser
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [time_width-1:0]     in_time,
  input  logic [data_width-1:0]     in_data,
  // records released downstream
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [time_width-1:0]     out_time,
  output logic [data_width-1:0]     out_data,
  // timing status
  output logic                      unit_pulse,
  output logic                      send_hb_up_pulse,
  output logic [time_width-1:0]     time_elapsed,
  output logic                      stall_dn
);

  logic [unit_width-1:0] unit_len;
  logic [31:0]           hb_every;
  logic                  reset_time;
  logic [time_width-1:0] pc_time_elapsed;

  time_conf_regs #(
    .unit_width (unit_width),
    .time_width (time_width)
  ) u_regs (
    .clk (clk), .reset (reset),
    .s_axi_awaddr (s_axi_awaddr), .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready), .s_axi_wdata (s_axi_wdata),
    .s_axi_wstrb (s_axi_wstrb), .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wready (s_axi_wready), .s_axi_bresp (s_axi_bresp),
    .s_axi_bvalid (s_axi_bvalid), .s_axi_bready (s_axi_bready),
    .s_axi_araddr (s_axi_araddr), .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready), .s_axi_rdata (s_axi_rdata),
    .s_axi_rresp (s_axi_rresp), .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .time_elapsed (time_elapsed), .unit_len (unit_len),
    .hb_every (hb_every), .reset_time (reset_time)
  );

  time_mgr #(
    .unit_width (unit_width),
    .time_width (time_width)
  ) u_time (
    .clk (clk), .reset (reset),
    .unit_len (unit_len), .hb_every (hb_every), .reset_time (reset_time),
    .pc_time_elapsed (pc_time_elapsed), .unit_pulse (unit_pulse),
    .send_hb_up_pulse (send_hb_up_pulse), .time_elapsed (time_elapsed),
    .stall_dn (stall_dn)
  );

  replay_gate #(
    .time_width (time_width),
    .data_width (data_width)
  ) u_gate (
    .clk (clk), .reset (reset),
    .in_valid (in_valid), .in_ready (in_ready),
    .in_time (in_time), .in_data (in_data),
    .out_valid (out_valid), .out_ready (out_ready),
    .out_time (out_time), .out_data (out_data),
    .stall_dn (stall_dn), .pc_time_elapsed (pc_time_elapsed)
  );

endmodule

// File: design/time_conf_regs.sv
`timescale 1ns/1ps

module time_conf_regs import replay_pkg::*; #(
  parameter int unit_width = 16,
  parameter int time_width = 48
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] s_axi_awaddr,
  input  logic                      s_axi_awvalid,
  output logic                      s_axi_awready,
  input  logic [31:0]               s_axi_wdata,
  input  logic [3:0]                s_axi_wstrb,
  input  logic                      s_axi_wvalid,
  output logic                      s_axi_wready,
  output logic [1:0]                s_axi_bresp,
  output logic                      s_axi_bvalid,
  input  logic                      s_axi_bready,
  input  logic [reg_addr_width-1:0] s_axi_araddr,
  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,
  output logic [31:0]               s_axi_rdata,
  output logic [1:0]                s_axi_rresp,
  output logic                      s_axi_rvalid,
  input  logic                      s_axi_rready,
  input  logic [time_width-1:0]     time_elapsed,
  output logic [unit_width-1:0]     unit_len,
  output logic [31:0]               hb_every,
  output logic                      reset_time
);

  // captured write address and data, each side arrives on its own
  logic [reg_addr_width-1:0] aw_addr_q;
  logic [31:0]               wdata_q;
  logic [3:0]                wstrb_q;
  logic                      aw_held;
  logic                      w_held;
  logic                      wr_go;
  // upper wall clock bits frozen by a time_lo read
  logic [time_width-33:0]    time_hi_snap;

  // merge enabled bytes of a write into the old word
  function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // one write in flight, channels close until the response is taken
  assign s_axi_awready = !aw_held;
  assign s_axi_wready  = !w_held;
  // both halves present and response not yet raised
  assign wr_go         = aw_held && w_held && !s_axi_bvalid;

  // payload capture
  always_ff @(posedge clk) begin
    if (s_axi_awvalid && s_axi_awready) begin
      aw_addr_q <= s_axi_awaddr;
    end
    if (s_axi_wvalid && s_axi_wready) begin
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
  end

  // write side, bvalid comes two cycles after the last accept
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aw_held      <= 1'b0;
      w_held       <= 1'b0;
      s_axi_bvalid <= 1'b0;
      s_axi_bresp  <= axi_resp_okay;
      unit_len     <= unit_width'(4);
      hb_every     <= 32'd8;
      reset_time   <= 1'b0;
    end else begin
      reset_time <= 1'b0;
      if (s_axi_awvalid && s_axi_awready) begin
        aw_held <= 1'b1;
      end
      if (s_axi_wvalid && s_axi_wready) begin
        w_held <= 1'b1;
      end
      if (wr_go) begin
        s_axi_bvalid <= 1'b1;
        s_axi_bresp  <= axi_resp_okay;
        case (aw_addr_q)
          ctrl_addr: begin
            // restart pulse, only bit 0 of the low byte matters
            reset_time <= wstrb_q[0] && wdata_q[0];
          end
          unit_len_addr: begin
            unit_len <= unit_width'(apply_strb(32'(unit_len), wdata_q, wstrb_q));
          end
          hb_every_addr: begin
            hb_every <= apply_strb(hb_every, wdata_q, wstrb_q);
          end
          // wall clock words are read only
          default: begin
            s_axi_bresp <= axi_resp_slverr;
          end
        endcase
      end else if (s_axi_bvalid && s_axi_bready) begin
        // response taken, reopen both channels
        s_axi_bvalid <= 1'b0;
        aw_held      <= 1'b0;
        w_held       <= 1'b0;
      end
    end
  end

  // one read in flight
  assign s_axi_arready = !s_axi_rvalid;

  // read side, data one cycle after the address
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s_axi_rvalid <= 1'b0;
      s_axi_rresp  <= axi_resp_okay;
      s_axi_rdata  <= '0;
      time_hi_snap <= '0;
    end else if (s_axi_arvalid && s_axi_arready) begin
      s_axi_rvalid <= 1'b1;
      s_axi_rresp  <= axi_resp_okay;
      case (s_axi_araddr)
        ctrl_addr:     s_axi_rdata <= '0;
        unit_len_addr: s_axi_rdata <= 32'(unit_len);
        hb_every_addr: s_axi_rdata <= hb_every;
        time_lo_addr: begin
          s_axi_rdata  <= time_elapsed[31:0];
          // keep the upper half consistent with this low word
          time_hi_snap <= time_elapsed[time_width-1:32];
        end
        time_hi_addr:  s_axi_rdata <= 32'(time_hi_snap);
        default: begin
          s_axi_rdata <= '0;
          s_axi_rresp <= axi_resp_slverr;
        end
      endcase
    end else if (s_axi_rvalid && s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // responses wait for the host
  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid);
  a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
    (s_axi_rvalid && !s_axi_rready) |=> (s_axi_rvalid && $stable(s_axi_rdata)));

endmodule

// File: design/time_mgr.sv
`timescale 1ns/1ps

module time_mgr #(
  parameter int unit_width = 16,
  parameter int time_width = 48
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [unit_width-1:0] unit_len,
  input  logic [31:0]           hb_every,
  input  logic                  reset_time,
  input  logic [time_width-1:0] pc_time_elapsed,
  output logic                  unit_pulse,
  output logic                  send_hb_up_pulse,
  output logic [time_width-1:0] time_elapsed,
  output logic                  stall_dn
);

  // units counted since the last heartbeat, starts at one
  logic [31:0] units_since_hb;
  logic        hb_due;

  // one pulse per time unit, restarted together with the wall clock
  time_unit_pulser #(
    .unit_width    (unit_width)
  ) u_pulser (
    .clk           (clk),
    .reset         (reset),
    .restart       (reset_time),
    .clks_per_unit (unit_len),
    .unit_pulse    (unit_pulse)
  );

  // wall clock in time units
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      time_elapsed <= time_width'(1);
    end else if (reset_time) begin
      time_elapsed <= time_width'(1);
    end else if (unit_pulse) begin
      time_elapsed <= time_elapsed + time_width'(1);
    end
  end

  // hb_every of zero or one fires on every unit
  assign hb_due = (units_since_hb >= hb_every);

  // upstream heartbeat interval
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      units_since_hb   <= 32'd1;
      send_hb_up_pulse <= 1'b0;
    end else if (reset_time) begin
      units_since_hb   <= 32'd1;
      send_hb_up_pulse <= 1'b0;
    end else if (unit_pulse && hb_due) begin
      units_since_hb   <= 32'd1;
      send_hb_up_pulse <= 1'b1;
    end else if (unit_pulse) begin
      units_since_hb   <= units_since_hb + 32'd1;
      send_hb_up_pulse <= 1'b0;
    end else begin
      send_hb_up_pulse <= 1'b0;
    end
  end

  // held record is ahead of the wall clock, hold traffic
  // registered, so it trails the comparison by a cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stall_dn <= 1'b0;
    end else begin
      stall_dn <= (pc_time_elapsed > time_elapsed);
    end
  end

  // wall clock only moves backwards on a restart
  a_time_monotonic: assert property (@(posedge clk) disable iff (reset)
    !reset_time |=> (time_elapsed >= $past(time_elapsed)));

endmodule

// File: design/time_unit_pulser.sv
`timescale 1ns/1ps

module time_unit_pulser #(
  parameter int unit_width = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  restart,
  input  logic [unit_width-1:0] clks_per_unit,
  output logic                  unit_pulse
);

  logic [unit_width-1:0] cnt;
  // length latched at each wrap, zero until the first wrap after reset
  logic [unit_width-1:0] len_q;
  logic [unit_width-1:0] eff_len;
  logic [unit_width-1:0] target;
  logic                  wrap;

  // a unit length of zero behaves as one cycle
  assign eff_len = (clks_per_unit == '0) ? unit_width'(1) : clks_per_unit;
  // first unit after reset runs on the live value
  assign target  = (len_q == '0) ? eff_len : len_q;
  assign wrap    = (cnt >= target - unit_width'(1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt        <= '0;
      len_q      <= '0;
      unit_pulse <= 1'b0;
    end else if (restart) begin
      // start a whole unit from here
      cnt        <= '0;
      len_q      <= eff_len;
      unit_pulse <= 1'b0;
    end else if (wrap) begin
      cnt        <= '0;
      // pick up a new length only here
      len_q      <= eff_len;
      unit_pulse <= 1'b1;
    end else begin
      cnt        <= cnt + unit_width'(1);
      unit_pulse <= 1'b0;
    end
  end

  // a unit longer than one cycle never produces back-to-back pulses
  a_pulse_single: assert property (@(posedge clk) disable iff (reset)
    (unit_pulse && target > unit_width'(1)) |=> !unit_pulse);

endmodule

// File: run.sh
#!/usr/bin/env bash
# build with verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module replay_timing_tb \
  -f tb.f -o replay_timing_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/replay_timing_sim > sim.log 2>&1
cat sim.log
! grep -q "Test failures found" sim.log && grep -q "All tests passed!" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

// File: tb.f
design/replay_pkg.sv
design/time_unit_pulser.sv
design/time_mgr.sv
design/time_conf_regs.sv
design/replay_gate.sv
design/replay_timing_top.sv
bench/replay_timing_tb.sv
